// ==== compile.f ====
+incdir+include
src/pf_data_pkg.sv
src/pf_status_pkg.sv
src/pf_sdpram.sv
src/pf_ptr_sync.sv
src/pf_fifo_ctrl.sv
src/pf_out_buffer.sv
src/pf_prefetch_fifo.sv
dv/pf_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pf_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/pf_tb.sv ====
// self-checking testbench for the prefetch FIFO; stimulus is fixed by seed, run is capped at 40000 rd_clk
`timescale 1ns/1ps
`include "pf_consts.svh"

module pf_tb;

  localparam int TIMEOUT_CYC = 40000;          // about four times the full test length
  localparam int RAND_WR_CYC = 12000;          // wr_clk cycles of random traffic
  localparam int IDLE_CYC    = 20;             // quiet rd_clk cycles after a drain
  localparam int OVERRUN_CYC = 16;             // write attempts while full

  // DUT ports
  logic                  wr_clk;
  logic                  wr_rst;
  logic                  wr_en;
  pf_data_pkg::word_t    wr_data;
  logic                  wr_vld;
  logic                  almost_full;
  pf_status_pkg::level_t wr_level;
  logic                  rd_clk;
  logic                  rd_rst;
  logic                  rd_en;
  pf_data_pkg::word_t    rd_data;
  logic                  rd_vld;
  logic                  almost_empty;
  pf_status_pkg::level_t rd_level;

  // reference model and bookkeeping
  pf_data_pkg::word_t    ref_q [$];            // accepted writes not yet read, in order
  int                    wr_total;             // accepted writes so far
  int                    rd_total;             // accepted reads so far
  int                    fill_base;            // wr_total when the fill test starts
  int                    fill_cnt;
  logic                  fill_check;           // exact level checks on the write side
  int                    rd_mode;              // 0 hold low, 1 random, 2 always high
  logic                  hold_prev;            // last edge saw rd_vld without rd_en
  pf_data_pkg::word_t    held_data;
  pf_data_pkg::word_t    exp_word;
  int                    rd_cycles;            // watchdog count

  pf_prefetch_fifo dut0 (
    .wr_clk       (wr_clk),
    .wr_rst       (wr_rst),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .wr_vld       (wr_vld),
    .almost_full  (almost_full),
    .wr_level     (wr_level),
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .rd_en        (rd_en),
    .rd_data      (rd_data),
    .rd_vld       (rd_vld),
    .almost_empty (almost_empty),
    .rd_level     (rd_level)
  );

  //////////////////////////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic show_mismatch(input string sig, input int got, input int exp);
    abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, sig, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // clocks, read driver, watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rd_clk = 1'b0;
    forever #20 rd_clk = ~rd_clk;              // 40 ns
  end

  initial
  begin
    wr_clk = 1'b0;
    forever #14 wr_clk = ~wr_clk;              // 28 ns period unrelated to rd_clk
  end

  always @(posedge rd_clk)
  begin
    case (rd_mode)
      0:       rd_en <= 1'b0;                  // back-pressure
      1:       rd_en <= ($urandom % 4) != 0;   // ready three times in four
      default: rd_en <= 1'b1;                  // drain
    endcase
  end

  always @(posedge rd_clk)
  begin
    rd_cycles++;
    if (rd_cycles >= TIMEOUT_CYC)
      abort_run("timeout: the test did not finish within the rd_clk cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // monitors, sampled at the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge wr_clk)
  begin
    if (!wr_rst)
    begin
      if (fill_check)
      begin
        fill_cnt = wr_total - fill_base;       // writes since the buffer filled
        assert (int'(wr_level) == fill_cnt)
          else show_mismatch("wr_level", int'(wr_level), fill_cnt);
        assert (almost_full == (fill_cnt >= `PF_AFULL_LVL))
          else show_mismatch("almost_full", int'(almost_full), int'(fill_cnt >= `PF_AFULL_LVL));
        assert (wr_vld == (fill_cnt < `PF_DEPTH))
          else show_mismatch("wr_vld", int'(wr_vld), int'(fill_cnt < `PF_DEPTH));
      end
      if (wr_en && wr_vld)
      begin
        ref_q.push_back(wr_data);              // transfer on this edge
        wr_total++;
      end
    end
  end

  always @(posedge rd_clk)
  begin
    if (!rd_rst)
    begin
      if (hold_prev)
      begin
        assert (rd_vld)
          else show_mismatch("rd_vld", int'(rd_vld), 1);
        assert (rd_data == held_data)
          else show_mismatch("rd_data", int'(rd_data), int'(held_data));
      end
      if (rd_vld)
      begin
        assert (ref_q.size() != 0)
          else abort_run("rd_vld is high although every written word was already read");
        if (rd_en)
        begin
          exp_word = ref_q.pop_front();        // head of the reference stream
          assert (rd_data == exp_word)
            else show_mismatch("rd_data", int'(rd_data), int'(exp_word));
          rd_total++;
        end
      end
      hold_prev = rd_vld & ~rd_en;
      held_data = rd_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  // read everything back, then the output must stay idle
  task automatic drain_fifo;
    while (rd_total != wr_total)
      @(negedge rd_clk);
    while (rd_level != '0)
      @(negedge rd_clk);
    repeat (IDLE_CYC)
    begin
      @(negedge rd_clk);
      assert (!rd_vld) else show_mismatch("rd_vld", int'(rd_vld), 0);
      assert (rd_level == '0) else show_mismatch("rd_level", int'(rd_level), 0);
      assert (almost_empty) else show_mismatch("almost_empty", int'(almost_empty), 1);
    end
  endtask

  initial
  begin
    void'($urandom(32'h180f));                 // one seed for the whole run
    wr_rst     <= 1'b1;
    rd_rst     <= 1'b1;
    wr_en      <= 1'b0;
    wr_data    <= '0;
    rd_en      <= 1'b0;
    rd_mode    = 0;
    fill_check = 1'b0;
    fill_base  = 0;
    wr_total   = 0;
    rd_total   = 0;
    rd_cycles  = 0;
    hold_prev  = 1'b0;
    held_data  = '0;

    fork
      begin
        repeat (10) @(posedge wr_clk);
        wr_rst <= 1'b0;
      end
      begin
        repeat (10) @(posedge rd_clk);
        rd_rst <= 1'b0;
      end
    join

    // reset state
    @(negedge rd_clk);
    assert (wr_vld) else show_mismatch("wr_vld", int'(wr_vld), 1);
    assert (!rd_vld) else show_mismatch("rd_vld", int'(rd_vld), 0);
    assert (almost_empty) else show_mismatch("almost_empty", int'(almost_empty), 1);
    assert (!almost_full) else show_mismatch("almost_full", int'(almost_full), 0);
    assert (wr_level == '0) else show_mismatch("wr_level", int'(wr_level), 0);
    assert (rd_level == '0) else show_mismatch("rd_level", int'(rd_level), 0);

    // two words fill the output buffer, which counts them as read
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= pf_data_pkg::word_t'($urandom);
    @(posedge wr_clk);
    wr_data <= pf_data_pkg::word_t'($urandom);
    @(posedge wr_clk);
    wr_en   <= 1'b0;
    do
      @(negedge wr_clk);
    while (wr_level != '0);                    // both prefetches seen on wr side

    // fill to full with rd_en low
    fill_base  = wr_total;
    fill_check = 1'b1;
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= pf_data_pkg::word_t'($urandom);
    do
    begin
      @(posedge wr_clk);
      wr_data <= pf_data_pkg::word_t'($urandom);
    end
    while (wr_vld);
    assert (wr_total - fill_base == `PF_DEPTH)
      else show_mismatch("accepted writes", wr_total - fill_base, `PF_DEPTH);
    repeat (OVERRUN_CYC)
    begin
      @(posedge wr_clk);
      wr_data <= 8'hee;                        // must be dropped
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
    @(negedge wr_clk);
    fill_check = 1'b0;

    // the whole RAM is waiting behind the two buffered words
    @(negedge rd_clk);
    assert (rd_level == `PF_DEPTH)
      else show_mismatch("rd_level", int'(rd_level), `PF_DEPTH);
    assert (!almost_empty) else show_mismatch("almost_empty", int'(almost_empty), 0);
    rd_mode = 2;
    drain_fifo();

    // random traffic on both sides
    @(negedge rd_clk);
    rd_mode = 1;
    repeat (RAND_WR_CYC)
    begin
      @(posedge wr_clk);
      wr_en   <= ($urandom % 3) != 0;
      wr_data <= pf_data_pkg::word_t'($urandom);
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
    @(negedge rd_clk);
    rd_mode = 2;
    drain_fifo();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== src/pf_prefetch_fifo.sv ====
// 1024x8 dual-clock prefetch FIFO top; wr_clk and rd_clk are treated as fully unrelated
`timescale 1ns/1ps

module pf_prefetch_fifo (
  // write side
  input  logic                  wr_clk,
  input  logic                  wr_rst,
  input  logic                  wr_en,          // valid
  input  pf_data_pkg::word_t    wr_data,
  output logic                  wr_vld,         // ready, not full
  output logic                  almost_full,
  output pf_status_pkg::level_t wr_level,
  // read side
  input  logic                  rd_clk,
  input  logic                  rd_rst,
  input  logic                  rd_en,          // ready
  output pf_data_pkg::word_t    rd_data,
  output logic                  rd_vld,         // valid
  output logic                  almost_empty,
  output pf_status_pkg::level_t rd_level
);

  pf_data_pkg::ram_wr_t      ram_wr;            // ctrl to RAM, wr_clk
  pf_data_pkg::ram_rd_t      ram_rd;            // ctrl to RAM, rd_clk
  pf_data_pkg::word_t        ram_word;          // RAM to buffer
  pf_status_pkg::wr_status_t wr_status;
  pf_status_pkg::rd_status_t rd_status;
  logic                      rd_req;            // buffer asks for a word

  //////////////////////////////////////////////////////////////////////
  // status to ports
  //////////////////////////////////////////////////////////////////////

  assign wr_vld       = ~wr_status.full;
  assign almost_full  = wr_status.almost_full;
  assign wr_level     = wr_status.level;        // counts buffered words as read
  assign almost_empty = rd_status.almost_empty;
  assign rd_level     = rd_status.level;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  pf_sdpram ram0 (
    .wr_clk  (wr_clk),
    .ram_wr  (ram_wr),
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .ram_rd  (ram_rd),
    .rd_word (ram_word)
  );

  pf_fifo_ctrl ctrl0 (
    .wr_clk    (wr_clk),
    .wr_rst    (wr_rst),
    .wr_en     (wr_en),
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .rd_req    (rd_req),
    .wr_data   (wr_data),
    .ram_wr    (ram_wr),
    .ram_rd    (ram_rd),
    .wr_status (wr_status),
    .rd_status (rd_status)
  );

  pf_out_buffer obuf0 (
    .rd_clk   (rd_clk),
    .rd_rst   (rd_rst),
    .empty    (rd_status.empty),
    .rd_req   (rd_req),
    .ram_word (ram_word),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_vld   (rd_vld)
  );

endmodule

// ==== src/pf_out_buffer.sv ====
// two-word prefetch buffer on rd_clk; assumes the RAM returns data exactly one clock after a request
`timescale 1ns/1ps

module pf_out_buffer (
  input  logic               rd_clk,
  input  logic               rd_rst,
  input  logic               empty,      // FIFO empty in the read view
  output logic               rd_req,     // prefetch one word
  input  pf_data_pkg::word_t ram_word,   // RAM output, valid when in_flight
  input  logic               rd_en,      // reader ready
  output pf_data_pkg::word_t rd_data,
  output logic               rd_vld
);

  logic [1:0]         cnt;               // words held, 0..2
  logic               in_flight;         // read issued last clk
  logic               pop;               // word taken this clk
  logic [1:0]         fill_after_pop;    // held + arriving - leaving
  pf_data_pkg::word_t slot0;             // head word
  pf_data_pkg::word_t slot1;             // second word

  //////////////////////////////////////////////////////////////////////
  // request and occupancy
  //////////////////////////////////////////////////////////////////////

  assign pop            = rd_vld & rd_en;
  assign fill_after_pop = cnt + {1'b0, in_flight} - {1'b0, pop};

  // counting this clk's pop lets a request go out every cycle while streaming
  assign rd_req  = ~empty & (fill_after_pop < 2'd2);
  assign rd_vld  = (cnt != 2'd0);
  assign rd_data = slot0;

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      cnt       <= '0;
      in_flight <= 1'b0;
    end
    else
    begin
      cnt       <= fill_after_pop;       // arriving word lands now
      in_flight <= rd_req;               // data shows up next clk
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload slots
  //////////////////////////////////////////////////////////////////////

  // cnt + in_flight never exceeds 2, so a pop with a word arriving means cnt is 1
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      slot0 <= '0;
      slot1 <= '0;
    end
    else if (pop)
    begin
      slot0 <= in_flight ? ram_word : slot1;   // refill or shift up
    end
    else if (in_flight)
    begin
      if (cnt == 2'd0)
      begin
        slot0 <= ram_word;               // straight to head
      end
      else
      begin
        slot1 <= ram_word;               // queue behind head
      end
    end
  end

endmodule

// ==== src/pf_fifo_ctrl.sv ====
// dual-clock pointer control; flags are conservative since the far pointer arrives 2-3 clks late
`timescale 1ns/1ps
`include "pf_consts.svh"

module pf_fifo_ctrl (
  input  logic                      wr_clk,
  input  logic                      wr_rst,
  input  logic                      wr_en,        // write valid
  input  logic                      rd_clk,
  input  logic                      rd_rst,
  input  logic                      rd_req,       // prefetch request from output buffer
  input  pf_data_pkg::word_t        wr_data,
  output pf_data_pkg::ram_wr_t      ram_wr,
  output pf_data_pkg::ram_rd_t      ram_rd,
  output pf_status_pkg::wr_status_t wr_status,
  output pf_status_pkg::rd_status_t rd_status
);

  // write domain
  logic                  wr_fire;                 // accepted write
  pf_status_pkg::ptr_t   wr_ptr;                  // binary with wrap bit
  pf_status_pkg::ptr_t   wr_ptr_nxt;
  pf_status_pkg::ptr_t   rd_gray_w;               // read ptr seen on wr_clk
  pf_status_pkg::ptr_t   rd_ptr_w;
  pf_status_pkg::level_t wr_level_nxt;

  // read domain
  logic                  rd_fire;                 // issued RAM read
  pf_status_pkg::ptr_t   rd_ptr;
  pf_status_pkg::ptr_t   rd_ptr_nxt;
  pf_status_pkg::ptr_t   wr_gray_r;               // write ptr seen on rd_clk
  pf_status_pkg::ptr_t   wr_ptr_r;
  pf_status_pkg::level_t rd_level_nxt;

  // gray back to binary from the msb down
  function automatic pf_status_pkg::ptr_t gray2bin(input pf_status_pkg::ptr_t gray);
    pf_status_pkg::ptr_t bin;
    bin[`PF_DEPTH_W] = gray[`PF_DEPTH_W];
    for (int i = `PF_DEPTH_W - 1; i >= 0; i--)
    begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  assign wr_fire      = wr_en & ~wr_status.full;   // same as wr_en && wr_vld
  assign wr_ptr_nxt   = wr_ptr + pf_status_pkg::ptr_t'(wr_fire);
  assign rd_ptr_w     = gray2bin(rd_gray_w);
  assign wr_level_nxt = wr_ptr_nxt - rd_ptr_w;     // wrap bit makes this exact

  assign ram_wr.en    = wr_fire;
  assign ram_wr.addr  = wr_ptr[`PF_DEPTH_W-1:0];   // drop wrap bit
  assign ram_wr.data  = wr_data;

  always_ff @(posedge wr_clk or posedge wr_rst)
  begin
    if (wr_rst)
    begin
      wr_ptr                <= '0;
      wr_status.full        <= 1'b0;
      wr_status.almost_full <= 1'b0;
      wr_status.level       <= '0;
    end
    else
    begin
      wr_ptr                <= wr_ptr_nxt;
      wr_status.full        <= (wr_level_nxt == pf_status_pkg::level_t'(`PF_DEPTH));
      wr_status.almost_full <= (wr_level_nxt >= pf_status_pkg::level_t'(`PF_AFULL_LVL));
      wr_status.level       <= wr_level_nxt;
    end
  end

  // next pointer goes in, so the launched gray matches wr_ptr cycle for cycle
  pf_ptr_sync wr_sync0 (
    .src_clk   (wr_clk),
    .src_rst   (wr_rst),
    .dst_clk   (rd_clk),
    .dst_rst   (rd_rst),
    .bin_ptr   (wr_ptr_nxt),
    .sync_gray (wr_gray_r)
  );

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  assign rd_fire      = rd_req & ~rd_status.empty;  // only while words remain
  assign rd_ptr_nxt   = rd_ptr + pf_status_pkg::ptr_t'(rd_fire);
  assign wr_ptr_r     = gray2bin(wr_gray_r);
  assign rd_level_nxt = wr_ptr_r - rd_ptr_nxt;

  assign ram_rd.en    = rd_fire;
  assign ram_rd.addr  = rd_ptr[`PF_DEPTH_W-1:0];

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      rd_ptr                 <= '0;
      rd_status.empty        <= 1'b1;              // nothing written yet
      rd_status.almost_empty <= 1'b1;
      rd_status.level        <= '0;
    end
    else
    begin
      rd_ptr                 <= rd_ptr_nxt;
      rd_status.empty        <= (rd_ptr_nxt == wr_ptr_r);   // pointers equal
      rd_status.almost_empty <= (rd_level_nxt <= pf_status_pkg::level_t'(`PF_AEMPTY_LVL));
      rd_status.level        <= rd_level_nxt;
    end
  end

  pf_ptr_sync rd_sync0 (
    .src_clk   (rd_clk),
    .src_rst   (rd_rst),
    .dst_clk   (wr_clk),
    .dst_rst   (wr_rst),
    .bin_ptr   (rd_ptr_nxt),
    .sync_gray (rd_gray_w)
  );

endmodule

// ==== src/pf_ptr_sync.sv ====
// gray pointer crossing; bin_ptr must step by at most one per src_clk for the gray code to hold
`timescale 1ns/1ps

module pf_ptr_sync (
  input  logic                src_clk,
  input  logic                src_rst,
  input  logic                dst_clk,
  input  logic                dst_rst,
  input  pf_status_pkg::ptr_t bin_ptr,    // binary pointer, source domain
  output pf_status_pkg::ptr_t sync_gray   // gray pointer, destination domain
);

  pf_status_pkg::ptr_t gray_src;          // launch register
  pf_status_pkg::ptr_t gray_meta;         // first sync stage

  //////////////////////////////////////////////////////////////////////
  // source domain
  //////////////////////////////////////////////////////////////////////

  // registered so no combinational glitch crosses
  always_ff @(posedge src_clk or posedge src_rst)
  begin
    if (src_rst)
    begin
      gray_src <= '0;
    end
    else
    begin
      gray_src <= bin_ptr ^ (bin_ptr >> 1);   // bin to gray
    end
  end

  //////////////////////////////////////////////////////////////////////
  // destination domain
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge dst_clk or posedge dst_rst)
  begin
    if (dst_rst)
    begin
      gray_meta <= '0;
      sync_gray <= '0;
    end
    else
    begin
      gray_meta <= gray_src;                 // may go metastable
      sync_gray <= gray_meta;                // settled copy
    end
  end

endmodule

// ==== src/pf_sdpram.sv ====
// simple dual-port RAM, write on wr_clk, one-clock registered read on rd_clk; no init contents
`timescale 1ns/1ps
`include "pf_consts.svh"

module pf_sdpram (
  input  logic                 wr_clk,
  input  pf_data_pkg::ram_wr_t ram_wr,   // write strobe, address, data
  input  logic                 rd_clk,
  input  logic                 rd_rst,
  input  pf_data_pkg::ram_rd_t ram_rd,   // read strobe and address
  output pf_data_pkg::word_t   rd_word   // valid one rd_clk after request
);

  //////////////////////////////////////////////////////////////////////
  // storage array
  //////////////////////////////////////////////////////////////////////

  pf_data_pkg::word_t mem [0:`PF_DEPTH-1];   // 1024 x 8, no reset

  // write port
  always_ff @(posedge wr_clk)
  begin
    if (ram_wr.en)
    begin
      mem[ram_wr.addr] <= ram_wr.data;       // full is checked upstream
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // output register only loads on a request, so the word holds otherwise
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      rd_word <= '0;                         // clean output after reset
    end
    else if (ram_rd.en)
    begin
      rd_word <= mem[ram_rd.addr];           // registered read
    end
  end

endmodule

// ==== src/pf_status_pkg.sv ====
// pointer and status types; pointers carry one wrap bit above the RAM address
`include "pf_consts.svh"

package pf_status_pkg;

  // binary or gray pointer with wrap bit
  typedef logic [`PF_DEPTH_W:0] ptr_t;

  // fill count 0..1024, needs the extra bit
  typedef logic [`PF_DEPTH_W:0] level_t;

  // write-side flags, all registered on wr_clk
  typedef struct packed {
    logic   full;                      // no room left
    logic   almost_full;               // at or above high mark
    level_t level;                     // words held, write view
  } wr_status_t;

  // read-side flags, all registered on rd_clk
  typedef struct packed {
    logic   empty;                     // nothing to prefetch
    logic   almost_empty;              // at or below low mark
    level_t level;                     // words held, read view
  } rd_status_t;

endpackage

// ==== src/pf_data_pkg.sv ====
// data-path types; word and address widths come from pf_consts.svh and are fixed at build
`include "pf_consts.svh"

package pf_data_pkg;

  // one stored byte
  typedef logic [`PF_DATA_W-1:0] word_t;

  // RAM word address, no wrap bit
  typedef logic [`PF_DEPTH_W-1:0] addr_t;

  // write port, wr_clk domain
  typedef struct packed {
    logic  en;                         // write strobe
    addr_t addr;                       // target word
    word_t data;                       // payload
  } ram_wr_t;

  // read request, rd_clk domain
  typedef struct packed {
    logic  en;                         // read strobe, data one clk later
    addr_t addr;                       // source word
  } ram_rd_t;

endpackage

// ==== include/pf_consts.svh ====
// sizes and flag thresholds for the 1024x8 prefetch FIFO; depth must stay a power of two
`ifndef PF_CONSTS_SVH
`define PF_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// storage geometry
//////////////////////////////////////////////////////////////////////

`define PF_DEPTH_W 10                  // address bits, 1024 words
`define PF_DATA_W 8                    // one byte per word

// word count, derived from the address width
`define PF_DEPTH (1 << `PF_DEPTH_W)

//////////////////////////////////////////////////////////////////////
// water marks
//////////////////////////////////////////////////////////////////////

// almost_full is set at or above this write level
`define PF_AFULL_LVL 1000

// almost_empty is set at or below this read level
`define PF_AEMPTY_LVL 8

`endif
